// ==== hdl/kvs_pkg.sv ====
`default_nettype none

package kvs_pkg;

	// request field widths
	localparam int hash_w = 32;
	localparam int key_w  = 96;
	localparam int val_w  = 32;
	localparam int flag_w = 4;

	// table geometry, the index is the low hash bits
	localparam int idx_w       = 10;
	localparam int table_depth = 1024;
	localparam int slots       = 4;
	localparam int slot_sel_w  = 2;

	// one slot is {valid, value, key}
	localparam int slot_w         = 1 + val_w + key_w;
	localparam int line_w         = slots * slot_w;
	localparam int slot_key_lo    = 0;
	localparam int slot_val_lo    = key_w;
	localparam int slot_valid_bit = key_w + val_w;

	// out_flag layout
	localparam int flag_op_bit   = 0;
	localparam int flag_state_lo = 1;
	localparam int flag_ok_bit   = 3;

	// set/get bit of a request
	localparam logic op_set = 1'b1;
	localparam logic op_get = 1'b0;

	// state codes carried in value bits 26:25
	localparam logic [1:0] state_idle    = 2'b00;
	localparam logic [1:0] state_suspect = 2'b01;
	localparam logic [1:0] state_arrest  = 2'b10;
	localparam logic [1:0] state_expire  = 2'b11;

	// cycles from in_valid to out_valid
	localparam int lookup_latency = 3;

	// stored value word, either raw or split into its fields
	typedef union packed {
		logic [val_w-1:0] raw;
		struct packed {
			logic [3:0]  user;
			logic        rsvd;
			logic [1:0]  state;
			logic        access;
			logic [23:0] payload;
		} fields;
	} kvs_value_u;

endpackage

`default_nettype wire

// ==== hdl/bucket_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module bucket_ram (
	input  wire logic                       clk156,
	input  wire logic [kvs_pkg::idx_w-1:0]  rd_index,
	output logic      [kvs_pkg::line_w-1:0] rd_line,
	input  wire logic                       wr_en,
	input  wire logic [kvs_pkg::idx_w-1:0]  wr_index,
	input  wire logic [kvs_pkg::line_w-1:0] wr_line
);
	import kvs_pkg::*;

	// one 516-bit line per bucket
	logic [line_w-1:0] mem [table_depth];

	// read-first: a same-index write shows up on the next read only
	always_ff @(posedge clk156) begin
		if (wr_en) begin
			mem[wr_index] <= wr_line;
		end
		rd_line <= mem[rd_index];
	end

	// the sweep and the update stage must always give a clean index
	a_wr_index_known: assert property (
		@(posedge clk156) wr_en |-> !$isunknown(wr_index)
	) else $error("bucket_ram write with unknown index");

endmodule

`default_nettype wire

// ==== hdl/kvs_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module kvs_lookup (
	input  wire logic                           clk156,
	input  wire logic                           rst,
	input  wire logic                           in_valid,
	input  wire logic                           in_op,
	input  wire logic [kvs_pkg::hash_w-1:0]     in_hash,
	input  wire logic [kvs_pkg::key_w-1:0]      in_key,
	input  wire logic [kvs_pkg::val_w-1:0]      in_value,
	input  wire logic                           init_done,
	input  wire logic [kvs_pkg::line_w-1:0]     rd_line,
	input  wire logic                           wr_en,
	input  wire logic [kvs_pkg::idx_w-1:0]      wr_index,
	input  wire logic [kvs_pkg::line_w-1:0]     wr_line,
	output logic                                dec_valid,
	output logic                                dec_op,
	output logic      [kvs_pkg::idx_w-1:0]      dec_index,
	output logic      [kvs_pkg::key_w-1:0]      dec_key,
	output logic      [kvs_pkg::val_w-1:0]      dec_value,
	output logic      [kvs_pkg::line_w-1:0]     dec_line,
	output logic                                dec_hit,
	output logic      [kvs_pkg::slot_sel_w-1:0] dec_slot,
	output logic                                dec_full
);
	import kvs_pkg::*;

	// request lined up with the ram output
	logic              req_valid;
	logic              req_op;
	logic [idx_w-1:0]  req_index;
	logic [key_w-1:0]  req_key;
	logic [val_w-1:0]  req_value;

	// last cycle's write, missed by a colliding read-first access
	logic              pw_en;
	logic [idx_w-1:0]  pw_index;
	logic [line_w-1:0] pw_line;

	logic [line_w-1:0]     cur_line;
	logic [slot_w-1:0]     cur_slot [slots];
	logic [slots-1:0]      slot_valid;
	logic [slots-1:0]      hit_vec;
	logic [slot_sel_w-1:0] hit_slot;
	logic [slot_sel_w-1:0] free_slot;
	logic                  any_hit;
	logic                  any_free;

	// requests before the table is cleared are dropped here
	always_ff @(posedge clk156) begin
		if (rst) begin
			req_valid <= 1'b0;
			pw_en     <= 1'b0;
		end else begin
			req_valid <= in_valid && init_done;
			pw_en     <= wr_en;
		end
	end

	always_ff @(posedge clk156) begin
		req_op    <= in_op;
		req_index <= in_hash[idx_w-1:0];
		req_key   <= in_key;
		req_value <= in_value;
		pw_index  <= wr_index;
		pw_line   <= wr_line;
	end

	// freshest copy of the bucket, the write in flight wins
	always_comb begin
		if (wr_en && wr_index == req_index) begin
			cur_line = wr_line;
		end else if (pw_en && pw_index == req_index) begin
			cur_line = pw_line;
		end else begin
			cur_line = rd_line;
		end
	end

	always_comb begin
		for (int i = 0; i < slots; i++) begin
			cur_slot[i]   = cur_line[i*slot_w +: slot_w];
			slot_valid[i] = cur_slot[i][slot_valid_bit];
			hit_vec[i]    = slot_valid[i] && (cur_slot[i][slot_key_lo +: key_w] == req_key);
		end
	end

	// scan downwards so the lowest slot number is kept
	always_comb begin
		hit_slot  = '0;
		free_slot = '0;
		for (int i = slots - 1; i >= 0; i--) begin
			if (hit_vec[i]) begin
				hit_slot = slot_sel_w'(i);
			end
			if (!slot_valid[i]) begin
				free_slot = slot_sel_w'(i);
			end
		end
	end

	assign any_hit  = |hit_vec;
	assign any_free = !(&slot_valid);

	always_ff @(posedge clk156) begin
		if (rst) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= req_valid;
		end
	end

	always_ff @(posedge clk156) begin
		dec_op    <= req_op;
		dec_index <= req_index;
		dec_key   <= req_key;
		dec_value <= req_value;
		dec_line  <= cur_line;
		dec_hit   <= any_hit;
		dec_slot  <= any_hit ? hit_slot : free_slot;
		dec_full  <= !any_hit && !any_free;
	end

	// a key lives in one slot only, which needs both forwarding and placement right
	a_single_match: assert property (
		@(posedge clk156) disable iff (rst) req_valid |-> $onehot0(hit_vec)
	) else $error("key found in more than one slot of bucket %0d", req_index);

endmodule

`default_nettype wire

// ==== hdl/kvs_update.sv ====
`timescale 1ns/1ps
`default_nettype none

module kvs_update (
	input  wire logic                           clk156,
	input  wire logic                           rst,
	input  wire logic                           dec_valid,
	input  wire logic                           dec_op,
	input  wire logic [kvs_pkg::idx_w-1:0]      dec_index,
	input  wire logic [kvs_pkg::key_w-1:0]      dec_key,
	input  wire logic [kvs_pkg::val_w-1:0]      dec_value,
	input  wire logic [kvs_pkg::line_w-1:0]     dec_line,
	input  wire logic                           dec_hit,
	input  wire logic [kvs_pkg::slot_sel_w-1:0] dec_slot,
	input  wire logic                           dec_full,
	output logic                                wr_en,
	output logic      [kvs_pkg::idx_w-1:0]      wr_index,
	output logic      [kvs_pkg::line_w-1:0]     wr_line,
	output logic                                init_done,
	output logic                                out_valid,
	output logic      [kvs_pkg::flag_w-1:0]     out_flag,
	output logic      [kvs_pkg::val_w-1:0]      out_value
);
	import kvs_pkg::*;

	// clear sweep after reset
	logic             sweep_on;
	logic [idx_w-1:0] sweep_idx;

	logic              upd_we;
	logic [slot_w-1:0] old_slot;
	logic [line_w-1:0] new_line;
	kvs_value_u        stored_val;
	kvs_value_u        new_val;
	logic [1:0]        rsp_state;
	logic              rsp_ok;

	// sweep runs from the first cycle without rst until init_done
	assign sweep_on = !rst && !init_done;

	// one bucket per cycle, init_done on the edge after the last one
	always_ff @(posedge clk156) begin
		if (rst) begin
			sweep_idx <= '0;
			init_done <= 1'b0;
		end else if (!init_done) begin
			sweep_idx <= sweep_idx + 1'b1;
			if (sweep_idx == idx_w'(table_depth - 1)) begin
				init_done <= 1'b1;
			end
		end
	end

	// slot being hit or filled
	assign old_slot       = dec_line[dec_slot*slot_w +: slot_w];
	assign stored_val.raw = old_slot[slot_val_lo +: val_w];
	assign new_val.raw    = dec_value;

	always_comb begin
		new_line = dec_line;
		new_line[dec_slot*slot_w +: slot_w] = {1'b1, dec_value, dec_key};
	end

	assign upd_we = dec_valid && (dec_op == op_set) && !dec_full;

	assign wr_en    = sweep_on || upd_we;
	assign wr_index = sweep_on ? sweep_idx : dec_index;
	assign wr_line  = sweep_on ? '0 : new_line;

	// response fields
	always_comb begin
		if (dec_op == op_set) begin
			rsp_state = new_val.fields.state;
			rsp_ok    = !dec_full;
		end else begin
			rsp_state = dec_hit ? stored_val.fields.state : state_idle;
			rsp_ok    = dec_hit;
		end
	end

	always_ff @(posedge clk156) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= dec_valid;
		end
	end

	// a hit returns what was in the slot, for both get and overwrite
	always_ff @(posedge clk156) begin
		out_flag[flag_op_bit]          <= dec_op;
		out_flag[flag_state_lo +: 2]   <= rsp_state;
		out_flag[flag_ok_bit]          <= rsp_ok;
		out_value                      <= dec_hit ? stored_val.raw : '0;
	end

	// gets and refused sets leave the table alone, and the sweep is over by then
	a_no_stray_write: assert property (
		@(posedge clk156) disable iff (rst)
		dec_valid && (dec_op == op_get || dec_full) |-> !wr_en
	) else $error("table written for a get or a refused set");

endmodule

`default_nettype wire

// ==== hdl/kvs_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module kvs_top (
	input  wire logic                       clk156,
	input  wire logic                       rst,
	input  wire logic                       in_valid,
	input  wire logic                       in_op,
	input  wire logic [kvs_pkg::hash_w-1:0] in_hash,
	input  wire logic [kvs_pkg::key_w-1:0]  in_key,
	input  wire logic [kvs_pkg::val_w-1:0]  in_value,
	output logic                            out_valid,
	output logic      [kvs_pkg::flag_w-1:0] out_flag,
	output logic      [kvs_pkg::val_w-1:0]  out_value,
	output logic                            init_done
);
	import kvs_pkg::*;

	logic [line_w-1:0]     rd_line;
	logic                  wr_en;
	logic [idx_w-1:0]      wr_index;
	logic [line_w-1:0]     wr_line;

	// decision register between the two stages
	logic                  dec_valid;
	logic                  dec_op;
	logic [idx_w-1:0]      dec_index;
	logic [key_w-1:0]      dec_key;
	logic [val_w-1:0]      dec_value;
	logic [line_w-1:0]     dec_line;
	logic                  dec_hit;
	logic [slot_sel_w-1:0] dec_slot;
	logic                  dec_full;

	bucket_ram i_bucket_ram (
		.clk156   (clk156),
		.rd_index (in_hash[idx_w-1:0]),
		.rd_line  (rd_line),
		.wr_en    (wr_en),
		.wr_index (wr_index),
		.wr_line  (wr_line)
	);

	kvs_lookup i_kvs_lookup (
		.clk156    (clk156),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_op     (in_op),
		.in_hash   (in_hash),
		.in_key    (in_key),
		.in_value  (in_value),
		.init_done (init_done),
		.rd_line   (rd_line),
		.wr_en     (wr_en),
		.wr_index  (wr_index),
		.wr_line   (wr_line),
		.dec_valid (dec_valid),
		.dec_op    (dec_op),
		.dec_index (dec_index),
		.dec_key   (dec_key),
		.dec_value (dec_value),
		.dec_line  (dec_line),
		.dec_hit   (dec_hit),
		.dec_slot  (dec_slot),
		.dec_full  (dec_full)
	);

	kvs_update i_kvs_update (
		.clk156    (clk156),
		.rst       (rst),
		.dec_valid (dec_valid),
		.dec_op    (dec_op),
		.dec_index (dec_index),
		.dec_key   (dec_key),
		.dec_value (dec_value),
		.dec_line  (dec_line),
		.dec_hit   (dec_hit),
		.dec_slot  (dec_slot),
		.dec_full  (dec_full),
		.wr_en     (wr_en),
		.wr_index  (wr_index),
		.wr_line   (wr_line),
		.init_done (init_done),
		.out_valid (out_valid),
		.out_flag  (out_flag),
		.out_value (out_value)
	);

endmodule

`default_nettype wire

// ==== dv/kvs_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module kvs_tb;
	import kvs_pkg::*;

	logic              clk156 = 1'b0;
	logic              rst;
	logic              in_valid;
	logic              in_op;
	logic [hash_w-1:0] in_hash;
	logic [key_w-1:0]  in_key;
	logic [val_w-1:0]  in_value;
	logic              out_valid;
	logic [flag_w-1:0] out_flag;
	logic [val_w-1:0]  out_value;
	logic              init_done;

	// edge count, bumped just before each rising edge
	int cycle_cnt = 0;
	int rng_seed  = 32'hfaf8;
	int num_req   = 0;
	int rsp_count = 0;

	// requests from the data file
	logic              op_q [$];
	logic [hash_w-1:0] hash_q [$];
	logic [key_w-1:0]  key_q [$];
	logic [val_w-1:0]  value_q [$];
	logic [flag_w-1:0] want_flag_q [$];
	logic [val_w-1:0]  want_value_q [$];
	logic              chain_q [$];

	// expectations of requests in flight
	logic [flag_w-1:0] exp_flag_q [$];
	logic [val_w-1:0]  exp_val_q [$];
	int                exp_cycle_q [$];
	int                exp_num_q [$];

	int rsp_num;
	int rsp_cycle;

	kvs_top i_dut (
		.clk156    (clk156),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_op     (in_op),
		.in_hash   (in_hash),
		.in_key    (in_key),
		.in_value  (in_value),
		.out_valid (out_valid),
		.out_flag  (out_flag),
		.out_value (out_value),
		.init_done (init_done)
	);

	always begin
		#2;
		cycle_cnt = cycle_cnt + 1;
		clk156 = 1'b1;
		#2;
		clk156 = 1'b0;
	end

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_flag(input logic [flag_w-1:0] got, input logic [flag_w-1:0] exp,
			input string what);
		if (got !== exp) begin
			stop_run($sformatf("CHECK FAILED at %0t: %s, out_flag %h expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_value(input kvs_value_u got, input kvs_value_u exp, input string what);
		if (got !== exp) begin
			stop_run($sformatf("CHECK FAILED at %0t: %s, out_value %h expected %h",
				$time, what, got.raw, exp.raw));
		end
	endtask

	task automatic compare_cycles(input int got, input int exp, input string what);
		if (got != exp) begin
			stop_run($sformatf("CHECK FAILED at %0t: %s, %0d cycles expected %0d",
				$time, what, got, exp));
		end
	endtask

	task automatic expect_low(input logic got, input string what);
		if (got !== 1'b0) begin
			stop_run($sformatf("CHECK FAILED at %0t: %s is %b, expected 0", $time, what, got));
		end
	endtask

	task automatic load_testdata();
		int                fd;
		int                cnt;
		string             line;
		logic [3:0]        f_op;
		logic [hash_w-1:0] f_hash;
		logic [key_w-1:0]  f_key;
		logic [val_w-1:0]  f_value;
		logic [flag_w-1:0] f_flag;
		logic [val_w-1:0]  f_exp;
		logic [3:0]        f_chain;
		fd = $fopen("dv/kvs_testdata.txt", "r");
		if (fd == 0) begin
			stop_run("could not open dv/kvs_testdata.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 0 && line.getc(0) != "#") begin
				cnt = $sscanf(line, "%h %h %h %h %h %h %h",
					f_op, f_hash, f_key, f_value, f_flag, f_exp, f_chain);
				if (cnt == 7) begin
					op_q.push_back(f_op[0]);
					hash_q.push_back(f_hash);
					key_q.push_back(f_key);
					value_q.push_back(f_value);
					want_flag_q.push_back(f_flag);
					want_value_q.push_back(f_exp);
					chain_q.push_back(f_chain[0]);
				end else if (cnt > 0) begin
					stop_run($sformatf("test data line is malformed: %s", line));
				end
			end
		end
		$fclose(fd);
		if (op_q.size() == 0) begin
			stop_run("test data file holds no requests");
		end
	endtask

	initial begin
		int gap;
		int release_cycle;
		rst      = 1'b1;
		in_valid = 1'b0;
		in_op    = op_get;
		in_hash  = '0;
		in_key   = '0;
		in_value = '0;
		void'($urandom(rng_seed));
		load_testdata();
		num_req = op_q.size();

		@(posedge clk156);
		@(negedge clk156);
		expect_low(out_valid, "out_valid during reset");
		expect_low(init_done, "init_done during reset");
		repeat (2) @(posedge clk156);
		rst <= 1'b0;
		release_cycle = cycle_cnt;
		@(negedge clk156);
		expect_low(init_done, "init_done right after reset");

		// one bucket cleared per cycle from the first cycle without rst
		while (init_done !== 1'b1) begin
			@(negedge clk156);
		end
		compare_cycles(cycle_cnt - release_cycle, table_depth, "init_done after reset");

		for (int n = 0; n < num_req; n++) begin
			if (!chain_q[n]) begin
				gap = $urandom % 4;
				repeat (gap) begin
					@(posedge clk156);
					in_valid <= 1'b0;
				end
			end
			@(posedge clk156);
			in_valid <= 1'b1;
			in_op    <= op_q[n];
			in_hash  <= hash_q[n];
			in_key   <= key_q[n];
			in_value <= value_q[n];
			exp_flag_q.push_back(want_flag_q[n]);
			exp_val_q.push_back(want_value_q[n]);
			exp_cycle_q.push_back(cycle_cnt);
			exp_num_q.push_back(n);
		end
		@(posedge clk156);
		in_valid <= 1'b0;

		while (rsp_count < num_req) begin
			@(posedge clk156);
		end
		// a few more cycles to catch a stray response
		repeat (lookup_latency + 2) @(posedge clk156);
		if (rsp_count != num_req || exp_flag_q.size() != 0) begin
			$display("got %0d responses for %0d requests", rsp_count, num_req);
			$display("Simulation finished: FAIL");
			$fatal(1, "response count wrong");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

	// responses come back in order, so the oldest expectation is next
	always @(negedge clk156) begin
		if (out_valid === 1'b1) begin
			if (exp_flag_q.size() == 0) begin
				stop_run("a response arrived with no request outstanding");
			end else begin
				rsp_num   = exp_num_q.pop_front();
				rsp_cycle = exp_cycle_q.pop_front();
				compare_cycles(cycle_cnt - rsp_cycle, lookup_latency,
					$sformatf("request %0d latency", rsp_num));
				check_flag(out_flag, exp_flag_q.pop_front(),
					$sformatf("request %0d", rsp_num));
				check_value(out_value, exp_val_q.pop_front(),
					$sformatf("request %0d", rsp_num));
				rsp_count = rsp_count + 1;
			end
		end
	end

	initial begin
		int limit_ns;
		wait (num_req > 0);
		limit_ns = (table_depth + num_req * 7 + 100) * 4;
		#(limit_ns);
		$display("timeout, responses stopped arriving after %0d of %0d", rsp_count, num_req);
		$display("Simulation finished: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// ==== dv/kvs_testdata.txt ====
# op hash key value exp_flag exp_value chain, all in hex
# op 1 is set and 0 is get, chain 1 issues the request in the cycle after the previous one
0 00000011 000000000000000000000aa1 00000000 0 00000000 0
0 000003ff 000000000000000000000aa2 00000000 0 00000000 1
1 00000022 0000000000000000000000b1 02123456 b 00000000 0
0 00000022 0000000000000000000000b1 00000000 a 02123456 0
1 00000022 0000000000000000000000b1 04abcdef d 02123456 0
0 00000022 0000000000000000000000b1 00000000 c 04abcdef 0
1 00000155 00000000000000000000c001 06000001 f 00000000 0
1 10000155 00000000000000000000c002 10000002 9 00000000 1
1 20000155 00000000000000000000c003 21000003 9 00000000 1
1 abc00155 00000000000000000000c004 3e000004 f 00000000 1
1 fff00555 00000000000000000000c005 42000005 3 00000000 1
0 fff00555 00000000000000000000c005 00000000 0 00000000 1
0 00000155 00000000000000000000c001 00000000 e 06000001 1
0 10000155 00000000000000000000c002 00000000 8 10000002 1
0 20000155 00000000000000000000c003 00000000 8 21000003 1
0 abc00155 00000000000000000000c004 00000000 e 3e000004 1
1 20000155 00000000000000000000c003 0a000033 b 21000003 0
0 20000155 00000000000000000000c003 00000000 a 0a000033 1
1 000002a0 0000000000000000000000d1 0400aaaa d 00000000 0
0 000002a0 0000000000000000000000d1 00000000 c 0400aaaa 1
1 000002a0 0000000000000000000000d1 0200bbbb b 0400aaaa 1
1 000012a0 0000000000000000000000d2 00000c0c 9 00000000 1
0 00000022 0000000000000000000000b1 00000000 c 04abcdef 1
0 000002a0 0000000000000000000000d1 00000000 a 0200bbbb 1
0 000012a0 0000000000000000000000d2 00000000 8 00000c0c 1
1 000002a0 0000000000000000000000d1 0600dddd f 0200bbbb 1
0 000002a0 0000000000000000000000d1 00000000 e 0600dddd 1
0 000002a0 0000000000000000000000d1 00000000 e 0600dddd 0

// ==== project.f ====
hdl/kvs_pkg.sv
hdl/bucket_ram.sv
hdl/kvs_lookup.sv
hdl/kvs_update.sv
hdl/kvs_top.sv
dv/kvs_tb.sv
